// ==== logic/uart_config.svh ====
// UART build constants, included by every block that sizes a FIFO, counter or divisor
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

////////////////////
// fifo geometry
`define UART_FIFO_DEPTH 16
`define UART_PTR_W 4          // log2 of the depth

////////////////////
// bit timing
`define UART_OVERSAMPLE_W 4   // 16 baud pulses per serial bit
`define UART_PRESCALE 0       // zero bits appended below the divisor

// low divisor byte out of reset, DLM clears to 0
`define UART_DLL_RESET 8'd1

`endif

// ==== logic/uartRegPkg.sv ====
// register map types of the UART, shared by the register block and both engines
package uartRegPkg;

  // byte offsets, several shared between read and write
  typedef enum logic [2:0] {
    addrRbr  = 3'd0,  // RBR read, THR write, DLL with DLAB
    addrIer  = 3'd1,  // DLM with DLAB
    addrIir  = 3'd2,  // IIR read, FCR write
    addrLcr  = 3'd3,
    addrMcr  = 3'd4,
    addrLsr  = 3'd5,
    addrMsr  = 3'd6,
    addrRsvd = 3'd7
  } regAddrT;

  typedef struct packed {
    logic       dlab;        // divisor latch access
    logic       setBreak;    // kept, no line effect
    logic       stickParity; // kept, no line effect
    logic       evenParity;
    logic       parityEn;
    logic       twoStops;
    logic [1:0] wordLen;     // 0 is 5 bits, 3 is 8 bits
  } lcrT;

  typedef struct packed {
    logic [1:0] trigLevel;   // rx trigger 1, 4, 8, 14
    logic       fifoEn;      // shows in IIR[7:6]
  } fcrT;

  typedef struct packed {
    logic fifoErr;   // some queued entry carries an error
    logic temt;      // fifo and shifter both empty
    logic thre;
    logic brk;
    logic framing;
    logic parity;
    logic overrun;
    logic dataReady;
  } lsrT;

  // interrupt identity, higher code wins
  typedef enum logic [2:0] {
    intrNone       = 3'd0,
    intrThrEmpty   = 3'd1,
    intrRxData     = 3'd2,
    intrLineStatus = 3'd3
  } intrIdT;

  // the part of LCR the serial engines need
  typedef struct packed {
    logic [1:0] wordLen;
    logic       parityEn;
    logic       evenParity;
    logic       twoStops;
  } frameCfgT;

endpackage

// ==== logic/uartLinePkg.sv ====
// serial line types, used by the transmitter, the receiver and the receive queue
package uartLinePkg;

  // engine state, done lasts one HCLK cycle
  typedef enum logic [1:0] {
    lineIdle   = 2'd0,
    lineActive = 2'd1,
    lineDone   = 2'd2
  } lineStateT;

  // one received character, error flags on top so the FIFO can OR them
  typedef struct packed {
    logic       overrun;
    logic       parityErr;
    logic       framingErr;
    logic [7:0] data;        // right aligned, upper bits zero
  } rxEntryT;

endpackage

// ==== logic/charFifo.sv ====
// circular FIFO with a typed entry, instanced once for tx bytes and once for rx entries
`timescale 1ns/1ps
`include "uart_config.svh"

module charFifo #(
  parameter type entryT = logic [7:0]
) (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic                 push,
  input  logic                 pop,
  input  logic                 clear,     // empties the queue
  input  entryT                wrEntry,
  output entryT                rdEntry,   // head of the queue
  output logic                 empty,
  output logic [`UART_PTR_W:0] count,
  output logic                 hasErr
);
  typedef logic [`UART_PTR_W-1:0] idxT;

  localparam int EntryW = $bits(entryT);
  localparam logic [`UART_PTR_W:0] Depth = `UART_FIFO_DEPTH;

  entryT mem [`UART_FIFO_DEPTH];
  logic [`UART_PTR_W:0] head, tail;        // extra msb tells full from empty
  logic [`UART_FIFO_DEPTH-1:0] entryErr;
  idxT offset;
  logic doPush, doPop;

  assign count   = head - tail;
  assign empty   = (count == '0);
  assign doPush  = push & (count != Depth); // full queue drops the write
  assign doPop   = pop & ~empty;
  assign rdEntry = mem[tail[`UART_PTR_W-1:0]];

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      head <= '0;
      tail <= '0;
    end else if (clear) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (doPush) head <= head + 1'b1;
      if (doPop) tail <= tail + 1'b1;
    end
  end

  always_ff @(posedge HCLK) begin
    if (doPush) mem[head[`UART_PTR_W-1:0]] <= wrEntry;
  end

  ////////////////////
  // error summary
  if (EntryW > 8) begin : gErr
    for (genvar i = 0; i < `UART_FIFO_DEPTH; i++) begin : gSlot
      assign entryErr[i] = |mem[i][EntryW-1 -: 3]; // top three bits are flags
    end
  end else begin : gNoErr
    assign entryErr = '0;                           // plain bytes carry no flags
  end

  // stale slots outside tail..head are ignored
  always_comb begin
    hasErr = 1'b0;
    for (int i = 0; i < `UART_FIFO_DEPTH; i++) begin
      offset = idxT'(i) - tail[`UART_PTR_W-1:0];
      if ({1'b0, offset} < count) hasErr = hasErr | entryErr[i];
    end
  end

endmodule

// ==== logic/baudGen.sv ====
// baud generator, one HCLK-wide pulse per oversample tick for both serial engines
`timescale 1ns/1ps
`include "uart_config.svh"

module baudGen (
  input  logic        HCLK,
  input  logic        HRESETn,
  input  logic [15:0] divisor,   // {DLM, DLL}
  input  logic        divLoad,   // divisor byte written
  output logic        baudPulse
);
  localparam int CntW = 16 + `UART_PRESCALE;

  logic [CntW-1:0] cnt, period;
  logic hit;

  assign period = CntW'(divisor) << `UART_PRESCALE; // prescale shift
  assign hit    = (cnt == period);

  // counts 1..period, the pulse is registered so it lands one cycle after the hit
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      cnt       <= CntW'(1);
      baudPulse <= 1'b0;
    end else if (divLoad) begin
      cnt       <= CntW'(1);   // restart, next pulse a full period away
      baudPulse <= 1'b0;
    end else begin
      cnt       <= hit ? CntW'(1) : cnt + 1'b1;
      baudPulse <= hit;
    end
  end

endmodule

// ==== logic/uartTx.sv ====
// UART transmitter, takes one byte from the tx FIFO, frames it and shifts it out LSB first
`timescale 1ns/1ps
`include "uart_config.svh"

module uartTx
  import uartRegPkg::*, uartLinePkg::*;
(
  input  logic       HCLK,
  input  logic       HRESETn,
  input  logic       baudPulse,
  input  frameCfgT   frameCfg,
  input  logic       txEmpty,
  input  logic [7:0] txHead,
  output logic       txPop,
  output logic       txBusy,
  output logic       serialOut
);
  lineStateT state;
  logic [`UART_OVERSAMPLE_W-1:0] ovCnt;
  logic [3:0]  bitCnt, bitsLast;
  logic [3:0]  dataBits;
  logic [7:0]  dataMask;
  logic [11:0] frame, shiftReg;     // msb is on the line
  logic        parityBit, bitEnd;

  assign dataBits  = 4'd5 + {2'b00, frameCfg.wordLen};
  assign dataMask  = 8'hff >> (2'd3 - frameCfg.wordLen);
  assign parityBit = ^(txHead & dataMask) ^ ~frameCfg.evenParity;
  // index of the last bit: start + data + parity + stops - 1
  assign bitsLast  = dataBits + {3'b000, frameCfg.parityEn}
                   + {3'b000, frameCfg.twoStops} + 4'd1;
  assign bitEnd    = baudPulse & (ovCnt == '1); // 16th pulse of a bit

  ////////////////////
  // frame builder
  always_comb begin
    frame     = 12'hfff;           // stop bits and padding
    frame[11] = 1'b0;              // start
    for (int i = 0; i < 8; i++) begin
      if (i < dataBits) frame[10 - i] = txHead[i];
    end
    if (frameCfg.parityEn) frame[4'd10 - dataBits] = parityBit;
  end

  assign txPop     = (state == lineIdle) & ~txEmpty; // pop and load together
  assign txBusy    = (state != lineIdle);
  assign serialOut = shiftReg[11];

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state    <= lineIdle;
      ovCnt    <= '0;
      bitCnt   <= '0;
      shiftReg <= 12'hfff;         // line idles high
    end else begin
      case (state)
        lineIdle: begin
          if (txPop) begin
            state    <= lineActive;
            ovCnt    <= '0;
            bitCnt   <= '0;
            shiftReg <= frame;     // start bit out on this edge
          end
        end
        lineActive: begin
          if (baudPulse) ovCnt <= ovCnt + 1'b1;
          if (bitEnd) begin
            shiftReg <= {shiftReg[10:0], 1'b1};
            bitCnt   <= bitCnt + 4'd1;
            if (bitCnt == bitsLast) state <= lineDone;
          end
        end
        default: state <= lineIdle; // done for one cycle
      endcase
    end
  end

endmodule

// ==== logic/uartRx.sv ====
// UART receiver, 16x oversampled, de-frames one character and flags its errors for the rx FIFO
`timescale 1ns/1ps
`include "uart_config.svh"

module uartRx
  import uartRegPkg::*, uartLinePkg::*;
(
  input  logic     HCLK,
  input  logic     HRESETn,
  input  logic     baudPulse,
  input  frameCfgT frameCfg,
  input  logic     serialIn,
  input  logic     rxFull,    // queue holds 15, next push overruns
  output logic     rxPush,
  output rxEntryT  rxEntry,
  output logic     rxDone     // stop bit sampled
);
  localparam logic [`UART_OVERSAMPLE_W-1:0] MidCnt = 1 << (`UART_OVERSAMPLE_W - 1);

  lineStateT state;
  logic sinMeta, sinSync;
  logic [`UART_OVERSAMPLE_W-1:0] ovCnt;
  logic [3:0] bitCnt, bitsLast, dataBits;
  logic [9:0] shiftReg;       // newest bit in [0], start bit falls off
  logic [7:0] rxData;
  logic sample, parityErr;

  assign dataBits = 4'd5 + {2'b00, frameCfg.wordLen};
  assign bitsLast = dataBits + {3'b000, frameCfg.parityEn} + 4'd1; // one stop checked
  assign sample   = baudPulse & (state == lineActive) & (ovCnt == MidCnt);
  assign rxDone   = sample & (bitCnt == bitsLast);
  assign rxPush   = (state == lineDone);

  ////////////////////
  // sync and bit timing
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sinMeta <= 1'b1;
      sinSync <= 1'b1;
      state   <= lineIdle;
      ovCnt   <= '0;
      bitCnt  <= '0;
    end else begin
      sinMeta <= serialIn;
      sinSync <= sinMeta;
      case (state)
        lineIdle: begin
          if (!sinSync) begin      // falling edge, start bit
            state  <= lineActive;
            ovCnt  <= '0;
            bitCnt <= '0;
          end
        end
        lineActive: begin
          if (baudPulse) ovCnt <= ovCnt + 1'b1;
          if (sample) bitCnt <= bitCnt + 4'd1;
          if (sample && bitCnt == 4'd0 && sinSync) state <= lineIdle; // glitch, not a start
          else if (rxDone) state <= lineDone;
        end
        default: state <= lineIdle;
      endcase
    end
  end

  always_ff @(posedge HCLK) begin
    if (sample) shiftReg <= {shiftReg[8:0], sinSync};
  end

  ////////////////////
  // de-framing, data sits just above parity and stop
  always_comb begin
    rxData = 8'h00;
    for (int i = 0; i < 8; i++) begin
      if (i < dataBits) rxData[i] = shiftReg[dataBits + frameCfg.parityEn - i];
    end
  end

  // parity bit lands in [1] when enabled
  assign parityErr = frameCfg.parityEn & (shiftReg[1] ^ ^rxData ^ ~frameCfg.evenParity);
  assign rxEntry   = {rxFull, parityErr, ~shiftReg[0], rxData};

endmodule

// ==== logic/uartRegs.sv ====
// UART register file: byte bus decode, read mux, line status and interrupt priority
`timescale 1ns/1ps
`include "uart_config.svh"

module uartRegs
  import uartRegPkg::*, uartLinePkg::*;
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  regAddrT              addr,
  input  logic [7:0]           din,
  input  logic                 memRb,
  input  logic                 memWb,
  output logic [7:0]           dout,
  output logic                 intr,
  input  logic                 txEmpty,
  input  logic                 txBusy,
  input  rxEntryT              rxHead,
  input  logic                 rxEmpty,
  input  logic [`UART_PTR_W:0] rxCount,
  input  logic                 rxHasErr,
  input  logic                 rxPush,
  input  rxEntryT              rxEntry,   // entry being pushed
  output frameCfgT             frameCfg,
  output logic [15:0]          divisor,
  output logic                 divLoad,
  output logic                 txPush,
  output logic [7:0]           txByte,
  output logic                 rxPop,
  output logic                 txFifoClr,
  output logic                 rxFifoClr,
  output logic                 loop
);
  typedef logic [`UART_PTR_W:0] countT;

  lcrT  lcr;
  fcrT  fcr;
  lsrT  lsr;
  logic [2:0] ier;            // line status, thre, rx data enables
  logic [7:0] dll, dlm;
  logic [2:0] errSticky;      // framing, parity, overrun as in LSR[3:1]
  logic threSquash;
  intrIdT intrId;
  countT trigCount;
  logic wrEn, rdEn;

  assign wrEn = ~memWb;
  assign rdEn = ~memRb;

  ////////////////////
  // bus strobes
  assign txPush    = wrEn & (addr == addrRbr) & ~lcr.dlab;
  assign txByte    = din;
  assign rxPop     = rdEn & (addr == addrRbr) & ~lcr.dlab;  // pop at the end of the read
  assign divLoad   = wrEn & lcr.dlab & ((addr == addrRbr) | (addr == addrIer));
  assign txFifoClr = wrEn & (addr == addrIir) & din[2];
  assign rxFifoClr = wrEn & (addr == addrIir) & din[1];
  assign divisor   = {dlm, dll};
  assign frameCfg  = {lcr.wordLen, lcr.parityEn, lcr.evenParity, lcr.twoStops};

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      lcr  <= '0;
      fcr  <= '0;
      ier  <= '0;
      dll  <= `UART_DLL_RESET;
      dlm  <= 8'h00;
      loop <= 1'b0;
    end else if (wrEn) begin
      case (addr)
        addrRbr: if (lcr.dlab) dll <= din;
        addrIer: begin
          if (lcr.dlab) dlm <= din;
          else ier <= din[2:0];
        end
        addrIir: fcr <= {din[7:6], din[0]}; // reset bits 2:1 self-clear
        addrLcr: lcr <= din;
        addrMcr: loop <= din[4];
        default: ;                           // LSR handled below, MSR and 7 ignored
      endcase
    end
  end

  ////////////////////
  // line status
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      errSticky <= '0;
    end else if (wrEn && addr == addrLsr) begin
      errSticky <= errSticky | din[3:1];     // test path, 6:4 follow the datapath
    end else begin
      errSticky <= ((rdEn && addr == addrLsr) ? 3'b000 : errSticky)
                 | (rxPush ? {rxEntry.framingErr, rxEntry.parityErr, rxEntry.overrun}
                           : 3'b000);
    end
  end

  always_comb begin
    lsr.fifoErr   = rxHasErr;
    lsr.temt      = txEmpty & ~txBusy;
    lsr.thre      = txEmpty;
    lsr.brk       = 1'b0;
    lsr.framing   = errSticky[2];
    lsr.parity    = errSticky[1];
    lsr.overrun   = errSticky[0];
    lsr.dataReady = ~rxEmpty;
  end

  ////////////////////
  // interrupts
  always_comb begin
    case (fcr.trigLevel)
      2'd0:    trigCount = countT'(1);
      2'd1:    trigCount = countT'(4);
      2'd2:    trigCount = countT'(8);
      default: trigCount = countT'(14);
    endcase
  end

  always_comb begin
    if (ier[2] && errSticky != 3'b000) intrId = intrLineStatus;
    else if (ier[0] && rxCount >= trigCount) intrId = intrRxData;
    else if (ier[1] && txEmpty && !threSquash) intrId = intrThrEmpty;
    else intrId = intrNone;
  end

  // an IIR read that showed THRE hides it until the tx FIFO fills again
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      threSquash <= 1'b0;
      intr       <= 1'b0;
    end else begin
      threSquash <= txEmpty
                  & (threSquash | (rdEn & (addr == addrIir) & (intrId == intrThrEmpty)));
      intr       <= (intrId != intrNone); // one cycle behind, glitch free
    end
  end

  ////////////////////
  // read mux
  always_comb begin
    dout = 8'h00;
    if (rdEn) begin
      case (addr)
        addrRbr: dout = lcr.dlab ? dll : rxHead.data;
        addrIer: dout = lcr.dlab ? dlm : {5'b00000, ier};
        addrIir: dout = {{2{fcr.fifoEn}}, 2'b00, intrId, 1'b1};
        addrLcr: dout = lcr;
        addrMcr: dout = {3'b000, loop, 4'b0000};
        addrLsr: dout = lsr;
        default: dout = 8'h00;              // no modem status, no scratch
      endcase
    end
  end

endmodule

// ==== logic/uartTop.sv ====
// UART top level, ties registers, baud generator, both engines, both FIFOs and loopback
`timescale 1ns/1ps
`include "uart_config.svh"

module uartTop
  import uartRegPkg::*, uartLinePkg::*;
(
  input  logic       HCLK,
  input  logic       HRESETn,
  input  regAddrT    addr,
  input  logic [7:0] din,
  input  logic       memRb,
  input  logic       memWb,
  output logic [7:0] dout,
  output logic       intr,
  input  logic       sin,
  output logic       sout
);
  localparam logic [`UART_PTR_W:0] FullMark = `UART_FIFO_DEPTH - 1;

  frameCfgT frameCfg;
  logic [15:0] divisor;
  logic divLoad, baudPulse, loop;
  logic txPush, txPop, txEmpty, txBusy, txFifoClr, txLine;
  logic [7:0] txByte, txHead;
  logic rxPush, rxPop, rxEmpty, rxHasErr, rxFifoClr, rxFull, rxIn;
  logic [`UART_PTR_W:0] rxCount;
  rxEntryT rxEntry, rxHead;

  assign rxFull = (rxCount == FullMark);       // overrun mark for the receiver
  assign rxIn   = loop ? txLine : sin;         // internal loopback
  assign sout   = loop ? 1'b1 : txLine;        // pin parked high in loop

  uartRegs regs (
    .HCLK, .HRESETn, .addr, .din, .memRb, .memWb, .dout, .intr,
    .txEmpty, .txBusy, .rxHead, .rxEmpty, .rxCount, .rxHasErr, .rxPush, .rxEntry,
    .frameCfg, .divisor, .divLoad, .txPush, .txByte, .rxPop,
    .txFifoClr, .rxFifoClr, .loop
  );

  baudGen baud (
    .HCLK, .HRESETn, .divisor, .divLoad, .baudPulse
  );

  charFifo #(.entryT(logic [7:0])) txFifo (
    .HCLK, .HRESETn,
    .push(txPush), .pop(txPop), .clear(txFifoClr), .wrEntry(txByte),
    .rdEntry(txHead), .empty(txEmpty), .count(), .hasErr()
  );

  uartTx tx (
    .HCLK, .HRESETn, .baudPulse, .frameCfg, .txEmpty, .txHead,
    .txPop, .txBusy, .serialOut(txLine)
  );

  uartRx rx (
    .HCLK, .HRESETn, .baudPulse, .frameCfg, .serialIn(rxIn), .rxFull,
    .rxPush, .rxEntry, .rxDone()                // push follows one cycle later
  );

  charFifo #(.entryT(rxEntryT)) rxFifo (
    .HCLK, .HRESETn,
    .push(rxPush), .pop(rxPop), .clear(rxFifoClr), .wrEntry(rxEntry),
    .rdEntry(rxHead), .empty(rxEmpty), .count(rxCount), .hasErr(rxHasErr)
  );

endmodule

// ==== verification/uart_asserts.sv ====
// bound checker for the UART top level, concurrent assertions on bus, interrupt and serial pins
`timescale 1ns/1ps

module uartAsserts (
  input logic       HCLK,
  input logic       HRESETn,
  input logic       memRb,
  input logic       memWb,
  input logic [7:0] dout,
  input logic       intr,
  input logic       sout,
  input logic       loop
);
  int   failCount = 0;  // failed assertions so far
  logic wrSeen;         // any write since reset

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) wrSeen <= 1'b0;
    else if (!memWb) wrSeen <= 1'b1;
  end

  ////////////////////
  // serial pin
  loopParked: assert property (@(posedge HCLK) disable iff (!HRESETn) loop |-> sout)
    else begin
      failCount++;
      $error("sout dropped while internal loopback was on");
    end

  // nothing queued yet, so the line must idle
  quietLine: assert property (@(posedge HCLK) disable iff (!HRESETn) !wrSeen |-> sout)
    else begin
      failCount++;
      $error("sout went low before any register write");
    end

  ////////////////////
  // bus and interrupt
  readIdle: assert property (@(posedge HCLK) disable iff (!HRESETn) memRb |-> dout == 8'h00)
    else begin
      failCount++;
      $error("dout not zero without a read strobe");
    end

  intrReset: assert property (@(posedge HCLK) !HRESETn |-> !intr ##1 !intr)
    else begin
      failCount++;
      $error("intr high during reset or the cycle after it");
    end

endmodule

// attach to every uartTop, loop is the internal MCR bit
bind uartTop uartAsserts asserts (
  .HCLK, .HRESETn, .memRb, .memWb, .dout, .intr, .sout, .loop
);

// ==== verification/uartTb.sv ====
// directed testbench for uartTop, run from all.f with uartTb as the top module
`timescale 1ns/1ps
`include "uart_config.svh"

module uartTb
  import uartRegPkg::*;
;
  localparam int ClkNs     = 100;
  localparam int Divisor   = 2;
  localparam int BitCycles = (Divisor << `UART_PRESCALE) * (1 << `UART_OVERSAMPLE_W);
  localparam int FrameNs   = 12 * BitCycles * ClkNs;  // longest frame, padded
  localparam int NumFrames = 31;                      // 24 echo, 2 error, 4 trigger, 1 thre
  localparam longint TimeoutNs = 2 * NumFrames * FrameNs;

  logic HCLK = 1'b0;
  logic HRESETn, memRb, memWb, sin, intr, sout;
  regAddrT addr;
  logic [7:0] din, dout;
  int errors = 0;
  int seed = 32'h44566e14;

  uartTop uartTop_inst (.*);

  always #(ClkNs / 2) HCLK = ~HCLK;

  ////////////////////
  // checks
  task automatic checkFlag(input string name, input logic act, input logic exp);
    assert (act === exp) else begin
      errors++;
      $display("ERR %0t %s expected %0b actual %0b", $time, name, exp, act);
    end
  endtask

  task automatic checkIntr(input logic exp);
    @(negedge HCLK);          // intr is registered, settled by now
    checkFlag("intr", intr, exp);
  endtask

  ////////////////////
  // bus tasks
  task automatic writeReg(input regAddrT a, input logic [7:0] d);
    @(negedge HCLK);
    addr  = a;
    din   = d;
    memWb = 1'b0;
    @(negedge HCLK);
    memWb = 1'b1;
  endtask

  task automatic readReg(input regAddrT a, output logic [7:0] d);
    @(negedge HCLK);
    addr  = a;
    memRb = 1'b0;
    #10 d = dout;             // combinational read, side effect on the next edge
    @(negedge HCLK);
    memRb = 1'b1;
  endtask

  task automatic checkReg(input regAddrT a, input logic [7:0] exp, input string name);
    logic [7:0] v;
    readReg(a, v);
    assert (v === exp) else begin
      errors++;
      $display("ERR %0t dout(%s) expected %02h actual %02h", $time, name, exp, v);
    end
  endtask

  // poll LSR until the tx FIFO and shifter are both empty
  task automatic waitTxIdle();
    logic [7:0] v;
    v = 8'h00;
    while (!v[6]) readReg(addrLsr, v);
  endtask

  // start, 8 data LSB first, parity, stop, then two idle bits
  task automatic sendFrame(input logic [7:0] data, input logic par, input logic stopBit);
    logic [10:0] bits;
    bits = {stopBit, par, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(negedge HCLK);
      sin = bits[i];
      repeat (BitCycles - 1) @(negedge HCLK);
    end
    @(negedge HCLK);
    sin = 1'b1;
    repeat (2 * BitCycles) @(negedge HCLK);
  endtask

  // eight random bytes through the internal loop in one line format
  task automatic loopbackEcho(input logic [7:0] lcrVal, input logic [7:0] mask);
    logic [7:0] b, v;
    logic [7:0] expQ [$];
    writeReg(addrLcr, lcrVal);
    for (int i = 0; i < 8; i++) begin
      b = 8'($random(seed));
      expQ.push_back(b & mask);  // upper bits never leave the shifter
      writeReg(addrRbr, b);
    end
    waitTxIdle();
    while (expQ.size() > 0) begin
      readReg(addrLsr, v);
      checkFlag("LSR.dataReady", v[0], 1'b1);
      checkReg(addrRbr, expQ.pop_front(), "RBR");
    end
    readReg(addrLsr, v);
    checkFlag("LSR.dataReady", v[0], 1'b0);
  endtask

  ////////////////////
  // stimulus
  initial begin
    logic [7:0] b;
    logic [7:0] trigQ [$];
    HRESETn = 1'b0;
    addr    = addrRbr;
    din     = 8'h00;
    memRb   = 1'b1;
    memWb   = 1'b1;
    sin     = 1'b1;
    repeat (2) @(negedge HCLK);
    HRESETn = 1'b1;

    // reset values
    checkReg(addrLsr, 8'h60, "LSR");
    checkReg(addrIir, 8'h01, "IIR");
    checkFlag("intr", intr, 1'b0);
    checkFlag("sout", sout, 1'b1);

    // divisor latch, then IER behind the same address
    writeReg(addrLcr, 8'h80);
    writeReg(addrRbr, 8'(Divisor));
    writeReg(addrIer, 8'h5a);
    checkReg(addrRbr, 8'(Divisor), "DLL");
    checkReg(addrIer, 8'h5a, "DLM");
    writeReg(addrIer, 8'h00);
    checkReg(addrIer, 8'h00, "DLM");
    writeReg(addrLcr, 8'h03);
    writeReg(addrIer, 8'h05);
    checkReg(addrIer, 8'h05, "IER");
    writeReg(addrIer, 8'h00);

    // loopback in 8N1, 7E1, 5O2
    writeReg(addrMcr, 8'h10);
    loopbackEcho(8'h03, 8'hff);
    loopbackEcho(8'h1a, 8'h7f);
    loopbackEcho(8'h0c, 8'h1f);

    // receive errors from the pin, 8E1
    writeReg(addrMcr, 8'h00);
    writeReg(addrLcr, 8'h1b);
    writeReg(addrIer, 8'h04);
    sendFrame(8'ha5, ~(^8'ha5), 1'b1);  // parity flipped
    sendFrame(8'h3c, ^8'h3c, 1'b0);     // stop bit low
    checkIntr(1'b1);
    checkReg(addrIir, 8'h07, "IIR");
    checkReg(addrLsr, 8'hed, "LSR");    // fifoErr, temt, thre, framing, parity, ready
    checkIntr(1'b0);
    checkReg(addrLsr, 8'he1, "LSR");    // sticky bits gone, entries still queued
    checkReg(addrRbr, 8'ha5, "RBR");
    checkReg(addrRbr, 8'h3c, "RBR");
    checkReg(addrLsr, 8'h60, "LSR");

    // rx trigger level 4
    writeReg(addrLcr, 8'h03);
    writeReg(addrMcr, 8'h10);
    writeReg(addrIir, 8'h46);           // trigger code 1, both FIFOs cleared
    writeReg(addrIer, 8'h01);
    for (int i = 0; i < 4; i++) begin
      b = 8'($random(seed));
      trigQ.push_back(b);
      writeReg(addrRbr, b);
      waitTxIdle();
      checkIntr(i == 3);
    end
    checkReg(addrIir, 8'h05, "IIR");
    checkReg(addrRbr, trigQ.pop_front(), "RBR");
    checkIntr(1'b0);                    // three left, below the trigger
    while (trigQ.size() > 0) checkReg(addrRbr, trigQ.pop_front(), "RBR");

    // THRE interrupt, squash and rearm
    writeReg(addrIer, 8'h02);
    checkIntr(1'b1);
    checkReg(addrIir, 8'h03, "IIR");
    checkIntr(1'b0);
    b = 8'($random(seed));
    writeReg(addrRbr, b);
    waitTxIdle();
    checkIntr(1'b1);
    checkReg(addrIir, 8'h03, "IIR");
    checkReg(addrRbr, b, "RBR");
    writeReg(addrIer, 8'h00);

    repeat (4) @(negedge HCLK);
    $display("errors: %0d checks, %0d assertions", errors, uartTop_inst.asserts.failCount);
    if (errors == 0 && uartTop_inst.asserts.failCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  ////////////////////
  // watchdog
  initial begin
    #(TimeoutNs);
    $display("watchdog expired before the directed sequence finished");
    $display("Test failed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+logic
logic/uartRegPkg.sv
logic/uartLinePkg.sv
logic/charFifo.sv
logic/baudGen.sv
logic/uartTx.sv
logic/uartRx.sv
logic/uartRegs.sv
logic/uartTop.sv
verification/uart_asserts.sv
verification/uartTb.sv

// ==== Bender.yml ====
package:
  name: uart16550

sources:
  - include_dirs:
      - logic
    files:
      - logic/uartRegPkg.sv
      - logic/uartLinePkg.sv
      - logic/charFifo.sv
      - logic/baudGen.sv
      - logic/uartTx.sv
      - logic/uartRx.sv
      - logic/uartRegs.sv
      - logic/uartTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/uart_asserts.sv
      - verification/uartTb.sv
